// ==== source/fetch_pkg.sv ====
// ============================================================
// Shared fetch geometry, reset address and enums
// Imported by every block of the fetch front end
// ============================================================
package fetch_pkg;

  // ============================================================
  // Address and line geometry
  // ============================================================

  // Virtual fetch address width
  localparam int VADDR_W = 32;
  // Instructions per fetch line
  localparam int FETCH_WIDTH = 4;
  // One instruction
  localparam int INST_W = 32;
  // Full line of instructions
  localparam int LINE_W = FETCH_WIDTH * INST_W;
  // Byte offset bits inside a 16-byte line
  localparam int LINE_OFFSET_W = 4;
  // Line stride in bytes
  localparam int LINE_BYTES = 1 << LINE_OFFSET_W;

  // ============================================================
  // Instruction memory and queue sizing
  // ============================================================

  // Lines held in the instruction memory
  localparam int IMEM_LINES = 64;
  // Line index, taken from address bits 9..4
  localparam int IMEM_IDX_W = 6;
  // Fetch address queue entries
  localparam int FAQ_DEPTH = 4;
  // Queue entry is address plus lane mask
  localparam int FAQ_DATA_W = VADDR_W + FETCH_WIDTH;

  // First fetch address out of reset
  localparam logic [VADDR_W-1:0] RESET_PC = 32'h0000_0100;

  // ============================================================
  // Enums
  // ============================================================

  // Fetch unit FSM
  typedef enum logic {
    FU_IDLE,
    FU_WAIT
  } fu_state_e;

  // Memory operation from arbiter to memory
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_READ,
    MEM_WRITE
  } mem_op_e;

endpackage

// ==== source/sync_fifo.sv ====
// ============================================================
// Show-ahead synchronous FIFO with flush
// Head entry is visible on data_o whenever empty_o is low
// ============================================================
module sync_fifo #(
  parameter int DEPTH  = 4,
  parameter int DATA_W = 8
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              flush_i,
  input  logic              push_i,
  input  logic              pop_i,
  input  logic [DATA_W-1:0] data_i,
  output logic [DATA_W-1:0] data_o,
  output logic              empty_o,
  output logic              full_o
);

  // Pointer keeps one bit even for a single entry
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push_ok;
  logic              pop_ok;

  // Strobes ignored when they cannot be served
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));
  // Show-ahead head
  assign data_o  = mem[rd_ptr];

  // Storage array, payload only
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        // Wrap also for non power of two depth
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
    end
  end

endmodule

// ==== source/fetch_address_queue.sv ====
// ============================================================
// Fetch address queue between next-PC generation and fetch
// Entries hold a line address and its lane-valid mask
// ============================================================
module fetch_address_queue (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                flush_i,
  input  logic                                push_i,
  input  logic [fetch_pkg::VADDR_W-1:0]       push_vaddr_i,
  input  logic [fetch_pkg::FETCH_WIDTH-1:0]   push_mask_i,
  output logic                                full_o,
  input  logic                                pop_i,
  output logic                                empty_o,
  output logic [fetch_pkg::VADDR_W-1:0]       head_vaddr_o,
  output logic [fetch_pkg::FETCH_WIDTH-1:0]   head_mask_o
);
  import fetch_pkg::*;

  logic [FAQ_DATA_W-1:0] wdata;
  logic [FAQ_DATA_W-1:0] rdata;

  // Address in the upper bits, mask in the lower
  assign wdata = {push_vaddr_i, push_mask_i};
  assign {head_vaddr_o, head_mask_o} = rdata;

  sync_fifo #(
    .DEPTH  (FAQ_DEPTH),
    .DATA_W (FAQ_DATA_W)
  ) u_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .push_i  (push_i),
    .pop_i   (pop_i),
    .data_i  (wdata),
    .data_o  (rdata),
    .empty_o (empty_o),
    .full_o  (full_o)
  );

endmodule

// ==== source/next_pc_gen.sv ====
// ============================================================
// Sequential next-line fetch address generator
// Pushes one line per cycle into the queue, restarts on redirect
// ============================================================
module next_pc_gen (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              redirect_i,
  input  logic [fetch_pkg::VADDR_W-1:0]     redirect_pc_i,
  input  logic                              full_i,
  output logic                              push_o,
  output logic [fetch_pkg::VADDR_W-1:0]     vaddr_o,
  output logic [fetch_pkg::FETCH_WIDTH-1:0] mask_o
);
  import fetch_pkg::*;

  logic [VADDR_W-1:0]     cur_vaddr;
  logic [FETCH_WIDTH-1:0] cur_mask;
  // Goes high one cycle after reset release
  logic                   run_q;

  // Clear the byte offset inside the line
  function automatic logic [VADDR_W-1:0] line_align(input logic [VADDR_W-1:0] pc);
    return {pc[VADDR_W-1:LINE_OFFSET_W], {LINE_OFFSET_W{1'b0}}};
  endfunction

  // Lanes from the word offset up to the last lane
  function automatic logic [FETCH_WIDTH-1:0] first_mask(input logic [VADDR_W-1:0] pc);
    logic [LINE_OFFSET_W-3:0] word_off;
    word_off = pc[LINE_OFFSET_W-1:2];
    return {FETCH_WIDTH{1'b1}} << word_off;
  endfunction

  // No push on a redirect cycle, the queue is being flushed
  assign push_o  = run_q & ~full_i & ~redirect_i;
  assign vaddr_o = cur_vaddr;
  assign mask_o  = cur_mask;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q     <= 1'b0;
      cur_vaddr <= line_align(RESET_PC);
      cur_mask  <= first_mask(RESET_PC);
    end else begin
      run_q <= 1'b1;
      if (redirect_i) begin
        // Restart at the target line
        cur_vaddr <= line_align(redirect_pc_i);
        cur_mask  <= first_mask(redirect_pc_i);
      end else if (push_o) begin
        // Next sequential line, all lanes
        cur_vaddr <= cur_vaddr + VADDR_W'(LINE_BYTES);
        cur_mask  <= '1;
      end
    end
  end

endmodule

// ==== source/imem_arbiter.sv ====
// ============================================================
// Fixed-priority arbiter for the shared instruction memory
// Load port always wins, fetch reads get the idle cycles
// ============================================================
module imem_arbiter (
  input  logic                             clk,
  input  logic                             rst_n_i,
  // External line-load port
  input  logic                             load_we_i,
  input  logic [fetch_pkg::IMEM_IDX_W-1:0] load_idx_i,
  input  logic [fetch_pkg::LINE_W-1:0]     load_data_i,
  // Fetch unit read port
  input  logic                             rd_req_i,
  input  logic [fetch_pkg::IMEM_IDX_W-1:0] rd_idx_i,
  output logic                             rd_gnt_o,
  // Memory side
  output fetch_pkg::mem_op_e               mem_op_o,
  output logic [fetch_pkg::IMEM_IDX_W-1:0] mem_idx_o,
  output logic [fetch_pkg::LINE_W-1:0]     mem_wdata_o
);
  import fetch_pkg::*;

  // Read grant of the previous cycle, read data lands now
  logic rd_gnt_q;

  // Read only when the load port is quiet
  assign rd_gnt_o = rd_req_i & ~load_we_i;

  always_comb begin
    mem_op_o    = MEM_IDLE;
    mem_idx_o   = rd_idx_i;
    mem_wdata_o = load_data_i;
    if (load_we_i) begin
      mem_op_o  = MEM_WRITE;
      mem_idx_o = load_idx_i;
    end else if (rd_req_i) begin
      mem_op_o  = MEM_READ;
    end
  end

  // Grant flag tracked across the read latency
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_gnt_q <= 1'b0;
    end else begin
      rd_gnt_q <= rd_gnt_o;
    end
  end

endmodule

// ==== source/inst_mem.sv ====
// ============================================================
// Single-port instruction line memory
// Writes on MEM_WRITE, registered read one cycle after MEM_READ
// ============================================================
module inst_mem (
  input  logic                             clk,
  input  fetch_pkg::mem_op_e               mem_op_i,
  input  logic [fetch_pkg::IMEM_IDX_W-1:0] mem_idx_i,
  input  logic [fetch_pkg::LINE_W-1:0]     mem_wdata_i,
  output logic [fetch_pkg::LINE_W-1:0]     mem_rdata_o
);
  import fetch_pkg::*;

  // ============================================================
  // Storage
  // ============================================================

  logic [LINE_W-1:0] lines [IMEM_LINES];

  // One port, one operation per cycle
  always_ff @(posedge clk) begin
    case (mem_op_i)
      MEM_WRITE: begin
        lines[mem_idx_i] <= mem_wdata_i;
      end
      MEM_READ: begin
        // Data valid on the next cycle
        mem_rdata_o <= lines[mem_idx_i];
      end
      default: begin
        // Idle, keep last read data
      end
    endcase
  end

endmodule

// ==== source/fetch_unit.sv ====
// ============================================================
// Fetch unit, turns queued line addresses into fetch bundles
// Holds the output bundle while inst_ready_i is low
// ============================================================
module fetch_unit (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              redirect_i,
  // Queue head
  input  logic                              faq_empty_i,
  input  logic [fetch_pkg::VADDR_W-1:0]     faq_vaddr_i,
  input  logic [fetch_pkg::FETCH_WIDTH-1:0] faq_mask_i,
  output logic                              faq_pop_o,
  // Memory read through the arbiter
  output logic                              rd_req_o,
  output logic [fetch_pkg::IMEM_IDX_W-1:0]  rd_idx_o,
  input  logic                              rd_gnt_i,
  input  logic [fetch_pkg::LINE_W-1:0]      mem_rdata_i,
  // Output bundle
  input  logic                              inst_ready_i,
  output logic                              inst_valid_o,
  output logic [fetch_pkg::VADDR_W-1:0]     inst_vaddr_o,
  output logic [fetch_pkg::FETCH_WIDTH-1:0] inst_mask_o,
  output logic [fetch_pkg::LINE_W-1:0]      inst_data_o
);
  import fetch_pkg::*;

  fu_state_e              state;
  logic                   out_free;
  logic                   capture;
  // Address and mask of the read in flight
  logic [VADDR_W-1:0]     pend_vaddr;
  logic [FETCH_WIDTH-1:0] pend_mask;

  // Output empty or being taken this cycle
  assign out_free = ~inst_valid_o | inst_ready_i;
  // No new read on a redirect cycle, its line would be stale
  assign rd_req_o  = (state == FU_IDLE) & ~faq_empty_i & out_free & ~redirect_i;
  assign rd_idx_o  = faq_vaddr_i[LINE_OFFSET_W +: IMEM_IDX_W];
  assign faq_pop_o = rd_req_o & rd_gnt_i;
  // Read data arrives in FU_WAIT, dropped on redirect
  assign capture   = (state == FU_WAIT) & ~redirect_i;

  // FSM and output valid
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state        <= FU_IDLE;
      inst_valid_o <= 1'b0;
    end else begin
      case (state)
        FU_IDLE: if (faq_pop_o) state <= FU_WAIT;
        default: state <= FU_IDLE;
      endcase
      if (capture) begin
        inst_valid_o <= 1'b1;
      end else if (inst_ready_i) begin
        inst_valid_o <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (faq_pop_o) begin
      pend_vaddr <= faq_vaddr_i;
      pend_mask  <= faq_mask_i;
    end
    if (capture) begin
      inst_vaddr_o <= pend_vaddr;
      inst_mask_o  <= pend_mask;
      inst_data_o  <= mem_rdata_i;
    end
  end

endmodule

// ==== source/fetch_top.sv ====
// ============================================================
// Instruction fetch front end, top level
// Next-PC generator, address queue, fetch unit and shared memory
// ============================================================
module fetch_top (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              redirect_i,
  input  logic [fetch_pkg::VADDR_W-1:0]     redirect_pc_i,
  input  logic                              load_we_i,
  input  logic [fetch_pkg::IMEM_IDX_W-1:0]  load_idx_i,
  input  logic [fetch_pkg::LINE_W-1:0]      load_data_i,
  input  logic                              inst_ready_i,
  output logic                              inst_valid_o,
  output logic [fetch_pkg::VADDR_W-1:0]     inst_vaddr_o,
  output logic [fetch_pkg::FETCH_WIDTH-1:0] inst_mask_o,
  output logic [fetch_pkg::LINE_W-1:0]      inst_data_o
);
  import fetch_pkg::*;

  // Generator to queue
  logic                   push;
  logic [VADDR_W-1:0]     push_vaddr;
  logic [FETCH_WIDTH-1:0] push_mask;
  logic                   faq_full;
  // Queue to fetch unit
  logic                   faq_empty;
  logic                   faq_pop;
  logic [VADDR_W-1:0]     faq_vaddr;
  logic [FETCH_WIDTH-1:0] faq_mask;
  // Memory path
  logic                   rd_req;
  logic                   rd_gnt;
  logic [IMEM_IDX_W-1:0]  rd_idx;
  mem_op_e                mem_op;
  logic [IMEM_IDX_W-1:0]  mem_idx;
  logic [LINE_W-1:0]      mem_wdata;
  logic [LINE_W-1:0]      mem_rdata;

  next_pc_gen u_next_pc_gen (
    .clk (clk), .rst_n_i (rst_n_i), .redirect_i (redirect_i),
    .redirect_pc_i (redirect_pc_i), .full_i (faq_full),
    .push_o (push), .vaddr_o (push_vaddr), .mask_o (push_mask)
  );

  // Redirect flushes every queued line
  fetch_address_queue u_faq (
    .clk (clk), .rst_n_i (rst_n_i), .flush_i (redirect_i),
    .push_i (push), .push_vaddr_i (push_vaddr), .push_mask_i (push_mask),
    .full_o (faq_full), .pop_i (faq_pop), .empty_o (faq_empty),
    .head_vaddr_o (faq_vaddr), .head_mask_o (faq_mask)
  );

  fetch_unit u_fetch_unit (
    .clk (clk), .rst_n_i (rst_n_i), .redirect_i (redirect_i),
    .faq_empty_i (faq_empty), .faq_vaddr_i (faq_vaddr), .faq_mask_i (faq_mask),
    .faq_pop_o (faq_pop), .rd_req_o (rd_req), .rd_idx_o (rd_idx),
    .rd_gnt_i (rd_gnt), .mem_rdata_i (mem_rdata), .inst_ready_i (inst_ready_i),
    .inst_valid_o (inst_valid_o), .inst_vaddr_o (inst_vaddr_o),
    .inst_mask_o (inst_mask_o), .inst_data_o (inst_data_o)
  );

  imem_arbiter u_arbiter (
    .clk (clk), .rst_n_i (rst_n_i), .load_we_i (load_we_i),
    .load_idx_i (load_idx_i), .load_data_i (load_data_i),
    .rd_req_i (rd_req), .rd_idx_i (rd_idx), .rd_gnt_o (rd_gnt),
    .mem_op_o (mem_op), .mem_idx_o (mem_idx), .mem_wdata_o (mem_wdata)
  );

  inst_mem u_inst_mem (
    .clk (clk), .mem_op_i (mem_op), .mem_idx_i (mem_idx),
    .mem_wdata_i (mem_wdata), .mem_rdata_o (mem_rdata)
  );

endmodule

// ==== verification/fetch_checker.sv ====
// ============================================================
// Assertions bound into fetch_top
// Queue push, output hold under back-pressure, memory owner
// ============================================================
module fetch_checker (
  input logic                              clk,
  input logic                              rst_n_i,
  input logic                              redirect_i,
  input logic                              push_i,
  input logic                              full_i,
  input logic                              empty_i,
  input logic                              rd_gnt_i,
  input logic                              rd_gnt_q_i,
  input logic                              load_we_i,
  input fetch_pkg::mem_op_e                mem_op_i,
  input logic                              inst_ready_i,
  input logic                              inst_valid_i,
  input logic [fetch_pkg::VADDR_W-1:0]     inst_vaddr_i,
  input logic [fetch_pkg::FETCH_WIDTH-1:0] inst_mask_i,
  input logic [fetch_pkg::LINE_W-1:0]      inst_data_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  // Generator never pushes into a full queue, pushed line is at the head next cycle
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    push_i |-> (!full_i ##1 !empty_i))
    else $error("Push into full fetch address queue or pushed line lost");

  // Pending bundle holds until taken
  a_bundle_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (inst_valid_i && !inst_ready_i) |=>
      (inst_valid_i && $stable(inst_vaddr_i) && $stable(inst_mask_i)
       && $stable(inst_data_i)))
    else $error("Fetch bundle changed while stalled");

  // Load port and fetch read never share a cycle, memory sees the read
  a_single_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_gnt_i |-> (!load_we_i && mem_op_i == MEM_READ))
    else $error("Read grant while the memory is not reading");

  // Granted read reaches the output unless a redirect drops it
  a_read_lands: assert property (@(posedge clk) disable iff (!rst_n_i)
    (rd_gnt_q_i && !redirect_i) |=> inst_valid_i)
    else $error("Granted read did not reach the output bundle");

endmodule

bind fetch_top fetch_checker u_checker (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .redirect_i   (redirect_i),
  .push_i       (push),
  .full_i       (faq_full),
  .empty_i      (faq_empty),
  .rd_gnt_i     (rd_gnt),
  .rd_gnt_q_i   (u_arbiter.rd_gnt_q),
  .load_we_i    (load_we_i),
  .mem_op_i     (mem_op),
  .inst_ready_i (inst_ready_i),
  .inst_valid_i (inst_valid_o),
  .inst_vaddr_i (inst_vaddr_o),
  .inst_mask_i  (inst_mask_o),
  .inst_data_i  (inst_data_o)
);

// ==== verification/fetch_tb.sv ====
// ============================================================
// Directed testbench for the instruction fetch front end
// Drives redirects, line loads and back-pressure into fetch_top
// ============================================================
module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import fetch_pkg::*;

  localparam int SEED    = 50574;
  // Cycles allowed for any single wait
  localparam int TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n_i;
  logic                   redirect_i;
  logic [VADDR_W-1:0]     redirect_pc_i;
  logic                   load_we_i;
  logic [IMEM_IDX_W-1:0]  load_idx_i;
  logic [LINE_W-1:0]      load_data_i;
  logic                   inst_ready_i;
  logic                   inst_valid_o;
  logic [VADDR_W-1:0]     inst_vaddr_o;
  logic [FETCH_WIDTH-1:0] inst_mask_o;
  logic [LINE_W-1:0]      inst_data_o;

  // Mirror of every line written through the load port
  logic [LINE_W-1:0] ref_lines [IMEM_LINES];
  // Set once a verdict line is out
  bit                verdict_done;

  fetch_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ============================================================
  // Reporting and reference rules
  // ============================================================

  task automatic report_failure(input string msg);
    $display("%s", msg);
    verdict_done = 1'b1;
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [LINE_W-1:0] exp,
                             input logic [LINE_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      verdict_done = 1'b1;
      $display("** FAIL **");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Lanes from the target word up to the last lane
  function automatic logic [FETCH_WIDTH-1:0] lane_mask(input logic [VADDR_W-1:0] target);
    logic [FETCH_WIDTH-1:0] m;
    for (int l = 0; l < FETCH_WIDTH; l++) begin
      m[l] = (l >= int'(target[3:2]));
    end
    return m;
  endfunction

  function automatic logic [LINE_W-1:0] random_line();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // ============================================================
  // Bus tasks
  // ============================================================

  // Leaves load_we_i high, so calls run back to back
  task automatic load_line(input logic [IMEM_IDX_W-1:0] idx, input logic [LINE_W-1:0] data);
    @(posedge clk);
    load_we_i   <= 1'b1;
    load_idx_i  <= idx;
    load_data_i <= data;
    ref_lines[idx] = data;
  endtask

  task automatic load_idle();
    @(posedge clk);
    load_we_i <= 1'b0;
  endtask

  // Ready is raised with the strobe to drop any bundle left at the output
  task automatic redirect_to(input logic [VADDR_W-1:0] target);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= target;
    inst_ready_i  <= 1'b1;
    @(posedge clk);
    redirect_i    <= 1'b0;
    inst_ready_i  <= 1'b0;
  endtask

  task automatic wait_valid(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (inst_valid_o !== 1'b1) begin
      if (cycles >= TIMEOUT) begin
        report_failure($sformatf("Timeout in %s: no fetch bundle arrived", name));
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  // One cycle of ready takes exactly one bundle
  task automatic accept_bundle();
    @(posedge clk);
    inst_ready_i <= 1'b1;
    @(posedge clk);
    inst_ready_i <= 1'b0;
  endtask

  task automatic expect_bundle(input string name, input logic [VADDR_W-1:0] exp_vaddr,
                               input logic [FETCH_WIDTH-1:0] exp_mask);
    wait_valid(name);
    check_value({name, " vaddr"}, LINE_W'(exp_vaddr), LINE_W'(inst_vaddr_o));
    check_value({name, " mask"}, LINE_W'(exp_mask), LINE_W'(inst_mask_o));
    check_value({name, " data"}, ref_lines[exp_vaddr[9:4]], inst_data_o);
    accept_bundle();
  endtask

  // Aligned target line first, then +16 with all lanes
  task automatic expect_stream(input string name, input logic [VADDR_W-1:0] target,
                               input int count);
    logic [VADDR_W-1:0]     addr;
    logic [FETCH_WIDTH-1:0] mask;
    addr = {target[VADDR_W-1:4], 4'b0000};
    mask = lane_mask(target);
    repeat (count) begin
      expect_bundle(name, addr, mask);
      addr = addr + 32'd16;
      mask = '1;
    end
  endtask

  // ============================================================
  // Directed tests
  // ============================================================

  task automatic sequential_fetch();
    for (int i = 0; i < IMEM_LINES; i++) begin
      load_line(IMEM_IDX_W'(i), random_line());
    end
    load_idle();
    redirect_to(RESET_PC);
    expect_stream("sequential", RESET_PC, 8);
  endtask

  task automatic unaligned_redirect();
    redirect_to(32'h0000_01C8);
    expect_stream("unaligned offset 8", 32'h0000_01C8, 2);
    redirect_to(32'h0000_0364);
    expect_stream("unaligned offset 4", 32'h0000_0364, 2);
  endtask

  task automatic backpressure_hold();
    logic [VADDR_W-1:0] exp_vaddr;
    logic [LINE_W-1:0]  held_data;
    exp_vaddr = 32'h0000_0040;
    redirect_to(exp_vaddr);
    wait_valid("backpressure");
    held_data = inst_data_o;
    check_value("backpressure data", ref_lines[exp_vaddr[9:4]], held_data);
    // Bundle pending with ready low
    repeat (20) begin
      @(negedge clk);
      check_value("backpressure hold valid", LINE_W'(1'b1), LINE_W'(inst_valid_o));
      check_value("backpressure hold vaddr", LINE_W'(exp_vaddr), LINE_W'(inst_vaddr_o));
      check_value("backpressure hold mask", LINE_W'(4'hF), LINE_W'(inst_mask_o));
      check_value("backpressure hold data", held_data, inst_data_o);
    end
    accept_bundle();
    expect_stream("backpressure resume", 32'h0000_0050, 6);
  endtask

  // Lines 40..47 rewritten while 32..35 are fetched, read later
  task automatic load_during_fetch();
    redirect_to(32'h0000_0200);
    fork
      begin
        for (int i = 40; i < 48; i++) begin
          load_line(IMEM_IDX_W'(i), random_line());
          if (($urandom() & 1) == 1) begin
            load_idle();
          end
        end
        load_idle();
      end
      expect_stream("load during fetch", 32'h0000_0200, 4);
    join
    expect_stream("load during fetch", 32'h0000_0240, 12);
  endtask

  // Gap of two idle cycles puts the first target's read in flight
  task automatic double_redirect();
    logic [VADDR_W-1:0] second;
    for (int gap = 0; gap < 4; gap++) begin
      second = 32'h0000_02F4 + VADDR_W'(gap * 'h40);
      redirect_to(32'h0000_00A4);
      repeat (gap) @(posedge clk);
      redirect_to(second);
      expect_stream("double redirect", second, 2);
    end
  endtask

  initial begin
    verdict_done = 1'b0;
    void'($urandom(SEED));
    rst_n_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    load_we_i     = 1'b0;
    load_idx_i    = '0;
    load_data_i   = '0;
    inst_ready_i  = 1'b0;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    sequential_fetch();
    unaligned_redirect();
    backpressure_hold();
    load_during_fetch();
    double_redirect();
    repeat (4) @(posedge clk);
    verdict_done = 1'b1;
    $display("** PASS **");
    $finish;
  end

  // Run ended without a verdict, a bound assertion stopped it
  final begin
    if (!verdict_done) begin
      $display("** FAIL **");
    end
  end

endmodule

// ==== filelist.f ====
source/fetch_pkg.sv
source/sync_fifo.sv
source/fetch_address_queue.sv
source/next_pc_gen.sv
source/imem_arbiter.sv
source/inst_mem.sv
source/fetch_unit.sv
source/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fetch front end with Verilator, run it, check the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module fetch_tb -f filelist.f \
  --Mdir "$BUILD_DIR" -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/fetch_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $LOG"
  exit 1
fi
